// File: src/sadPkg.sv
package sadPkg;

    // Command opcodes
    typedef enum logic [0:0] {
        opCompare = 1'b0,
        opClear   = 1'b1
    } sadOpE;

    // Pixel depth in bits
    localparam int DefPixelWidth = 8;

    // Frame size in pixels
    localparam int DefFrameWidth  = 16;
    localparam int DefFrameHeight = 16;

    // Block edge whose square gives the lane count
    localparam int DefBlockSize = 4;

endpackage

// File: src/blockFetch.sv
`timescale 1ns/1ns

module blockFetch #(
    parameter int PixelWidth  = sadPkg::DefPixelWidth,
    parameter int FrameWidth  = sadPkg::DefFrameWidth,
    parameter int FrameHeight = sadPkg::DefFrameHeight,
    parameter int BlockSize   = sadPkg::DefBlockSize,
    localparam int RowW  = $clog2(FrameHeight),
    localparam int ColW  = $clog2(FrameWidth),
    localparam int Lanes = BlockSize * BlockSize,
    localparam int AddrW = $clog2(FrameWidth * FrameHeight),
    localparam int IdxW  = $clog2(Lanes)
) (
    input  logic                        Clk,
    input  logic                        reset,
    input  logic                        pipeAdvance,
    input  logic                        frameWe,
    input  logic [AddrW-1:0]            frameAddr,
    input  logic [PixelWidth-1:0]       frameData,
    input  logic                        tmplWe,
    input  logic [IdxW-1:0]             tmplIdx,
    input  logic [PixelWidth-1:0]       tmplData,
    input  logic                        cmdValid,
    output logic                        cmdReady,
    input  sadPkg::sadOpE               cmdOp,
    input  logic [RowW-1:0]             cmdRow,
    input  logic [ColW-1:0]             cmdCol,
    output logic [Lanes*PixelWidth-1:0] frameBlock,
    output logic [Lanes*PixelWidth-1:0] tmplBlock,
    output logic                        fetchValid,
    output sadPkg::sadOpE               fetchOp,
    output logic [RowW-1:0]             fetchRow,
    output logic [ColW-1:0]             fetchCol
);

    logic [PixelWidth-1:0]       frameMem [FrameWidth*FrameHeight];
    logic [PixelWidth-1:0]       tmplMem [Lanes];
    logic [RowW-1:0]             blkRow [BlockSize];
    logic [ColW-1:0]             blkCol [BlockSize];
    logic [AddrW-1:0]            pixAddr [Lanes];
    logic [Lanes*PixelWidth-1:0] framePixels;
    logic [Lanes*PixelWidth-1:0] tmplPixels;
    logic                        cmdFire;

    // The whole pipeline moves as one, so a slot is free whenever it advances
    assign cmdReady = pipeAdvance;
    assign cmdFire  = cmdValid && cmdReady;

    // Write ports never stall
    always_ff @(posedge Clk) begin
        if (frameWe) begin
            frameMem[frameAddr] <= frameData;
        end
        if (tmplWe) begin
            tmplMem[tmplIdx] <= tmplData;
        end
    end

    // Block rows and columns wrapped at the frame edge
    for (genvar k = 0; k < BlockSize; k++) begin : genWrap
        logic [RowW:0] rowSum;
        logic [ColW:0] colSum;

        assign rowSum = {1'b0, cmdRow} + (RowW+1)'(k);
        assign colSum = {1'b0, cmdCol} + (ColW+1)'(k);
        assign blkRow[k] = (rowSum >= (RowW+1)'(FrameHeight)) ?
                           RowW'(rowSum - (RowW+1)'(FrameHeight)) : rowSum[RowW-1:0];
        assign blkCol[k] = (colSum >= (ColW+1)'(FrameWidth)) ?
                           ColW'(colSum - (ColW+1)'(FrameWidth)) : colSum[ColW-1:0];
    end

    // Lane i*BlockSize+j reads row i and column j of the block
    for (genvar lane = 0; lane < Lanes; lane++) begin : genAddr
        assign pixAddr[lane] = AddrW'(blkRow[lane / BlockSize] * FrameWidth)
                             + AddrW'(blkCol[lane % BlockSize]);
    end

    always_comb begin
        for (int lane = 0; lane < Lanes; lane++) begin
            framePixels[lane*PixelWidth +: PixelWidth] = frameMem[pixAddr[lane]];
            tmplPixels[lane*PixelWidth +: PixelWidth]  = tmplMem[lane];
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            fetchValid <= 1'b0;
        end else if (pipeAdvance) begin
            fetchValid <= cmdFire;
        end
    end

    // Pixel pairs and tag
    always_ff @(posedge Clk) begin
        if (pipeAdvance) begin
            frameBlock <= framePixels;
            tmplBlock  <= tmplPixels;
            fetchOp    <= cmdOp;
            fetchRow   <= cmdRow;
            fetchCol   <= cmdCol;
        end
    end

endmodule

// File: src/absDiffLane.sv
`timescale 1ns/1ns

module absDiffLane #(
    parameter int PixelWidth = sadPkg::DefPixelWidth
) (
    input  logic                  Clk,
    input  logic                  reset,
    input  logic                  pipeAdvance,
    input  logic [PixelWidth-1:0] framePix,
    input  logic [PixelWidth-1:0] tmplPix,
    output logic [PixelWidth-1:0] absDiff
);

    logic [PixelWidth-1:0] diff;

    // Larger minus smaller, so the result needs no sign bit
    assign diff = (framePix >= tmplPix) ? framePix - tmplPix : tmplPix - framePix;

    always_ff @(posedge Clk) begin
        if (reset) begin
            absDiff <= '0;
        end else if (pipeAdvance) begin
            absDiff <= diff;
        end
    end

endmodule

// File: src/sadReduceMin.sv
`timescale 1ns/1ns

module sadReduceMin #(
    parameter int PixelWidth  = sadPkg::DefPixelWidth,
    parameter int FrameWidth  = sadPkg::DefFrameWidth,
    parameter int FrameHeight = sadPkg::DefFrameHeight,
    parameter int BlockSize   = sadPkg::DefBlockSize,
    localparam int RowW  = $clog2(FrameHeight),
    localparam int ColW  = $clog2(FrameWidth),
    localparam int Lanes = BlockSize * BlockSize,
    localparam int SadW  = PixelWidth + 2 * $clog2(BlockSize)
) (
    input  logic                        Clk,
    input  logic                        reset,
    input  logic [Lanes*PixelWidth-1:0] laneDiffs,
    input  logic                        fetchValid,
    input  sadPkg::sadOpE               fetchOp,
    input  logic [RowW-1:0]             fetchRow,
    input  logic [ColW-1:0]             fetchCol,
    input  logic                        resultReady,
    output logic                        pipeAdvance,
    output logic                        resultValid,
    output logic [SadW-1:0]             resultSad,
    output logic [SadW-1:0]             minSad,
    output logic [RowW-1:0]             minRow,
    output logic [ColW-1:0]             minCol
);

    logic            tagValid;
    sadPkg::sadOpE   tagOp;
    logic [RowW-1:0] tagRow;
    logic [ColW-1:0] tagCol;
    logic [SadW-1:0] laneSum;
    logic            isCompare;
    logic            isClear;
    logic            newMin;

    // Stall only while a result waits to be taken
    assign pipeAdvance = !resultValid || resultReady;

    // Tag is delayed one stage to line up with the lane registers
    always_ff @(posedge Clk) begin
        if (reset) begin
            tagValid <= 1'b0;
        end else if (pipeAdvance) begin
            tagValid <= fetchValid;
        end
    end

    always_ff @(posedge Clk) begin
        if (pipeAdvance) begin
            tagOp  <= fetchOp;
            tagRow <= fetchRow;
            tagCol <= fetchCol;
        end
    end

    always_comb begin
        laneSum = '0;
        for (int lane = 0; lane < Lanes; lane++) begin
            laneSum = laneSum + SadW'(laneDiffs[lane*PixelWidth +: PixelWidth]);
        end
    end

    assign isCompare = tagValid && (tagOp == sadPkg::opCompare);
    assign isClear   = tagValid && (tagOp == sadPkg::opClear);
    // Strictly smaller only so that a tie keeps the earlier position
    assign newMin    = laneSum < minSad;

    // Running minimum doubles as the result output
    always_ff @(posedge Clk) begin
        if (reset) begin
            resultValid <= 1'b0;
            minSad      <= '1;
            minRow      <= '0;
            minCol      <= '0;
        end else if (pipeAdvance) begin
            resultValid <= isCompare;
            if (isClear) begin
                minSad <= '1;
                minRow <= '0;
                minCol <= '0;
            end else if (isCompare && newMin) begin
                minSad <= laneSum;
                minRow <= tagRow;
                minCol <= tagCol;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (pipeAdvance && isCompare) begin
            resultSad <= laneSum;
        end
    end

endmodule

// File: src/sadEngine.sv
`timescale 1ns/1ns

module sadEngine #(
    parameter int PixelWidth  = sadPkg::DefPixelWidth,
    parameter int FrameWidth  = sadPkg::DefFrameWidth,
    parameter int FrameHeight = sadPkg::DefFrameHeight,
    parameter int BlockSize   = sadPkg::DefBlockSize,
    localparam int RowW  = $clog2(FrameHeight),
    localparam int ColW  = $clog2(FrameWidth),
    localparam int Lanes = BlockSize * BlockSize,
    localparam int AddrW = $clog2(FrameWidth * FrameHeight),
    localparam int IdxW  = $clog2(Lanes),
    localparam int SadW  = PixelWidth + 2 * $clog2(BlockSize)
) (
    input  logic                  Clk,
    input  logic                  reset,
    input  logic                  frameWe,
    input  logic [AddrW-1:0]      frameAddr,
    input  logic [PixelWidth-1:0] frameData,
    input  logic                  tmplWe,
    input  logic [IdxW-1:0]       tmplIdx,
    input  logic [PixelWidth-1:0] tmplData,
    input  logic                  cmdValid,
    output logic                  cmdReady,
    input  sadPkg::sadOpE         cmdOp,
    input  logic [RowW-1:0]       cmdRow,
    input  logic [ColW-1:0]       cmdCol,
    output logic                  resultValid,
    input  logic                  resultReady,
    output logic [SadW-1:0]       resultSad,
    output logic [SadW-1:0]       minSad,
    output logic [RowW-1:0]       minRow,
    output logic [ColW-1:0]       minCol
);

    logic                        pipeAdvance;
    logic [Lanes*PixelWidth-1:0] frameBlock;
    logic [Lanes*PixelWidth-1:0] tmplBlock;
    logic [Lanes*PixelWidth-1:0] laneDiffs;
    logic                        fetchValid;
    sadPkg::sadOpE               fetchOp;
    logic [RowW-1:0]             fetchRow;
    logic [ColW-1:0]             fetchCol;

    blockFetch #(
        .PixelWidth (PixelWidth),
        .FrameWidth (FrameWidth),
        .FrameHeight(FrameHeight),
        .BlockSize  (BlockSize)
    ) fetch (
        .Clk        (Clk),
        .reset      (reset),
        .pipeAdvance(pipeAdvance),
        .frameWe    (frameWe),
        .frameAddr  (frameAddr),
        .frameData  (frameData),
        .tmplWe     (tmplWe),
        .tmplIdx    (tmplIdx),
        .tmplData   (tmplData),
        .cmdValid   (cmdValid),
        .cmdReady   (cmdReady),
        .cmdOp      (cmdOp),
        .cmdRow     (cmdRow),
        .cmdCol     (cmdCol),
        .frameBlock (frameBlock),
        .tmplBlock  (tmplBlock),
        .fetchValid (fetchValid),
        .fetchOp    (fetchOp),
        .fetchRow   (fetchRow),
        .fetchCol   (fetchCol)
    );

    // One absolute-difference lane per block pixel
    for (genvar lane = 0; lane < Lanes; lane++) begin : genLane
        absDiffLane #(
            .PixelWidth(PixelWidth)
        ) diffLane (
            .Clk        (Clk),
            .reset      (reset),
            .pipeAdvance(pipeAdvance),
            .framePix   (frameBlock[lane*PixelWidth +: PixelWidth]),
            .tmplPix    (tmplBlock[lane*PixelWidth +: PixelWidth]),
            .absDiff    (laneDiffs[lane*PixelWidth +: PixelWidth])
        );
    end

    sadReduceMin #(
        .PixelWidth (PixelWidth),
        .FrameWidth (FrameWidth),
        .FrameHeight(FrameHeight),
        .BlockSize  (BlockSize)
    ) reduce (
        .Clk        (Clk),
        .reset      (reset),
        .laneDiffs  (laneDiffs),
        .fetchValid (fetchValid),
        .fetchOp    (fetchOp),
        .fetchRow   (fetchRow),
        .fetchCol   (fetchCol),
        .resultReady(resultReady),
        .pipeAdvance(pipeAdvance),
        .resultValid(resultValid),
        .resultSad  (resultSad),
        .minSad     (minSad),
        .minRow     (minRow),
        .minCol     (minCol)
    );

endmodule

// File: testbench/sadEngine_sva.sv
`timescale 1ns/1ns

module sadEngineSva #(
    parameter int SadW = sadPkg::DefPixelWidth + 2 * $clog2(sadPkg::DefBlockSize),
    parameter int RowW = $clog2(sadPkg::DefFrameHeight),
    parameter int ColW = $clog2(sadPkg::DefFrameWidth)
) (
    input logic            Clk,
    input logic            reset,
    input logic            cmdReady,
    input logic            resultValid,
    input logic            resultReady,
    input logic [SadW-1:0] resultSad,
    input logic [SadW-1:0] minSad,
    input logic [RowW-1:0] minRow,
    input logic [ColW-1:0] minCol
);

    logic resultHeld;

    assign resultHeld = resultValid && !resultReady;

    resultIdleAfterReset: assert property (@(posedge Clk) reset |=> !resultValid)
        else $error("resultValid is high right after reset");

    // Result outputs stay frozen until the consumer takes them
    heldResultStable: assert property (@(posedge Clk) disable iff (reset)
        resultHeld |=> resultValid && $stable(resultSad) && $stable(minSad)
                       && $stable(minRow) && $stable(minCol))
        else $error("held result changed before it was taken");

    // The whole pipeline stalls behind a held result
    readyWhileHeld: assert property (@(posedge Clk) disable iff (reset)
        cmdReady == !resultHeld)
        else $error("cmdReady does not match the held result state");

endmodule

bind sadEngine sadEngineSva #(
    .SadW(SadW),
    .RowW(RowW),
    .ColW(ColW)
) sva (
    .Clk        (Clk),
    .reset      (reset),
    .cmdReady   (cmdReady),
    .resultValid(resultValid),
    .resultReady(resultReady),
    .resultSad  (resultSad),
    .minSad     (minSad),
    .minRow     (minRow),
    .minCol     (minCol)
);

// File: testbench/sadEngineTb.sv
`timescale 1ns/1ns

module sadEngineTb;

    localparam int PW         = sadPkg::DefPixelWidth;
    localparam int FW         = sadPkg::DefFrameWidth;
    localparam int FH         = sadPkg::DefFrameHeight;
    localparam int BS         = sadPkg::DefBlockSize;
    localparam int RowW       = $clog2(FH);
    localparam int ColW       = $clog2(FW);
    localparam int SadW       = PW + 2 * $clog2(BS);
    localparam int AddrW      = $clog2(FW * FH);
    localparam int IdxW       = $clog2(BS * BS);
    localparam int MinInit    = (1 << SadW) - 1;
    localparam int RunTimeout = 2000;
    // Accept edge to transfer edge with resultReady held high
    localparam int LatencyEdges = 3;
    localparam int NumCmds    = 14;

    // Fields are op, row, col; op 1 is a clear
    localparam logic [8:0] CmdTable [NumCmds] = '{
        {1'b1, 4'd0, 4'd0}, {1'b0, 4'd0, 4'd0}, {1'b0, 4'd5, 4'd7},
        {1'b0, 4'd14, 4'd3}, {1'b0, 4'd2, 4'd13}, {1'b0, 4'd15, 4'd15},
        {1'b1, 4'd0, 4'd0}, {1'b0, 4'd1, 4'd2}, {1'b0, 4'd9, 4'd10},
        {1'b0, 4'd6, 4'd6}, {1'b0, 4'd12, 4'd14}, {1'b1, 4'd0, 4'd0},
        {1'b1, 4'd0, 4'd0}, {1'b0, 4'd3, 4'd9}
    };
    localparam logic [PW-1:0] TmplTable [BS*BS] = '{
        8'h10, 8'hf0, 8'h80, 8'h3c, 8'h00, 8'hff, 8'h7f, 8'h81,
        8'h55, 8'haa, 8'h20, 8'hd0, 8'h44, 8'h99, 8'h07, 8'hc3
    };

    logic             Clk;
    logic             reset;
    logic             frameWe;
    logic [AddrW-1:0] frameAddr;
    logic [PW-1:0]    frameData;
    logic             tmplWe;
    logic [IdxW-1:0]  tmplIdx;
    logic [PW-1:0]    tmplData;
    logic             cmdValid;
    logic             cmdReady;
    sadPkg::sadOpE    cmdOp;
    logic [RowW-1:0]  cmdRow;
    logic [ColW-1:0]  cmdCol;
    logic             resultValid;
    logic             resultReady;
    logic [SadW-1:0]  resultSad;
    logic [SadW-1:0]  minSad;
    logic [RowW-1:0]  minRow;
    logic [ColW-1:0]  minCol;

    logic [31:0] rngState;
    int          frameRef [FW*FH];
    int          modelMin;
    int          modelRow;
    int          modelCol;
    int          expSad [$];
    int          expMin [$];
    int          expRow [$];
    int          expCol [$];
    int          expCycle [$];

    sadEngine #(
        .PixelWidth (PW),
        .FrameWidth (FW),
        .FrameHeight(FH),
        .BlockSize  (BS)
    ) uut (.*);

    always #20 Clk = ~Clk;

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic randomBit();
        logic [31:0] r;
        r = nextRandom();
        return r[4];
    endfunction

    // Reference SAD with the block wrapped at both frame edges
    function automatic int blockSad(input int row, input int col);
        int sum;
        int fr;
        int tp;
        sum = 0;
        for (int i = 0; i < BS; i++) begin
            for (int j = 0; j < BS; j++) begin
                fr = frameRef[((row + i) % FH) * FW + (col + j) % FW];
                tp = int'(TmplTable[i * BS + j]);
                sum += (fr > tp) ? fr - tp : tp - fr;
            end
        end
        return sum;
    endfunction

    task automatic compareValue(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic reportFailure(input string what);
        $display("%s at %0t ns", what, $time);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped on a failure");
    endtask

    task automatic presentCommand(input int idx);
        cmdValid <= 1'b1;
        cmdOp    <= sadPkg::sadOpE'(CmdTable[idx][8]);
        cmdRow   <= RowW'(CmdTable[idx][7:4]);
        cmdCol   <= ColW'(CmdTable[idx][3:0]);
    endtask

    task automatic acceptCommand(input logic [8:0] entry, input int cycle);
        int sad;
        if (sadPkg::sadOpE'(entry[8]) == sadPkg::opClear) begin
            modelMin = MinInit;
            modelRow = 0;
            modelCol = 0;
        end else begin
            sad = blockSad(int'(entry[7:4]), int'(entry[3:0]));
            // Strictly smaller only, so a tie keeps the earlier position
            if (sad < modelMin) begin
                modelMin = sad;
                modelRow = int'(entry[7:4]);
                modelCol = int'(entry[3:0]);
            end
            expSad.push_back(sad);
            expMin.push_back(modelMin);
            expRow.push_back(modelRow);
            expCol.push_back(modelCol);
            expCycle.push_back(cycle);
        end
    endtask

    task automatic checkResult(input int cycle, input bit steady);
        int acceptCycle;
        if (expSad.size() == 0) begin
            reportFailure("A result arrived with no compare pending");
        end else begin
            acceptCycle = expCycle.pop_front();
            compareValue("resultSad", int'(resultSad), expSad.pop_front());
            compareValue("minSad", int'(minSad), expMin.pop_front());
            compareValue("minRow", int'(minRow), expRow.pop_front());
            compareValue("minCol", int'(minCol), expCol.pop_front());
            if (steady) begin
                compareValue("result latency", cycle - acceptCycle, LatencyEdges);
            end
        end
    endtask

    // Called right after a rising edge; transfers are judged on pre-edge values
    task automatic runCommands(input bit steady);
        int cmdIdx;
        int cycle;
        cmdIdx = 0;
        cycle  = 0;
        presentCommand(0);
        resultReady <= steady ? 1'b1 : randomBit();
        while ((cmdIdx < NumCmds || expSad.size() > 0) && cycle < RunTimeout) begin
            @(posedge Clk);
            cycle++;
            if (resultValid && resultReady) begin
                checkResult(cycle, steady);
            end
            if (cmdValid && cmdReady) begin
                acceptCommand(CmdTable[cmdIdx], cycle);
                cmdIdx++;
                if (cmdIdx < NumCmds) begin
                    presentCommand(cmdIdx);
                end else begin
                    cmdValid <= 1'b0;
                end
            end
            resultReady <= steady ? 1'b1 : randomBit();
        end
        if (cmdIdx < NumCmds || expSad.size() > 0) begin
            reportFailure("Timed out before all commands and results completed");
        end
    endtask

    initial begin
        Clk         = 1'b0;
        reset       = 1'b1;
        frameWe     = 1'b0;
        frameAddr   = '0;
        frameData   = '0;
        tmplWe      = 1'b0;
        tmplIdx     = '0;
        tmplData    = '0;
        cmdValid    = 1'b0;
        cmdOp       = sadPkg::opCompare;
        cmdRow      = '0;
        cmdCol      = '0;
        resultReady = 1'b0;
        rngState    = 32'h18db_d6de;
        modelMin    = MinInit;
        modelRow    = 0;
        modelCol    = 0;
        for (int a = 0; a < FW * FH; a++) begin
            frameRef[a] = int'(nextRandom() & 32'h0000_00ff);
        end
        // Block at (9,10) copies the one at (1,2) so their SADs tie
        for (int i = 0; i < BS; i++) begin
            for (int j = 0; j < BS; j++) begin
                frameRef[(9 + i) * FW + 10 + j] = frameRef[(1 + i) * FW + 2 + j];
            end
        end

        repeat (2) @(posedge Clk);
        reset <= 1'b0;
        @(posedge Clk);
        compareValue("resultValid", int'(resultValid), 0);
        compareValue("cmdReady", int'(cmdReady), 1);

        for (int a = 0; a < FW * FH; a++) begin
            frameWe   <= 1'b1;
            frameAddr <= AddrW'(a);
            frameData <= PW'(frameRef[a]);
            @(posedge Clk);
        end
        frameWe <= 1'b0;
        for (int k = 0; k < BS * BS; k++) begin
            tmplWe   <= 1'b1;
            tmplIdx  <= IdxW'(k);
            tmplData <= TmplTable[k];
            @(posedge Clk);
        end
        tmplWe <= 1'b0;

        // Random back-pressure first, then a free-flowing pass
        runCommands(1'b0);
        runCommands(1'b1);

        // Clears must not leave any result behind
        repeat (10) begin
            @(posedge Clk);
            if (resultValid) begin
                reportFailure("A result appeared after the last compare was taken");
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: vlog.f
src/sadPkg.sv
src/blockFetch.sv
src/absDiffLane.sv
src/sadReduceMin.sv
src/sadEngine.sv
testbench/sadEngine_sva.sv
testbench/sadEngineTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module sadEngineTb -f vlog.f -o sadEngineSim

./obj_dir/sadEngineSim > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
echo "Testbench did not pass, see sim.log"
exit 1
